// File: build.f
src/rv_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_mem_wb.sv
src/rv_regfile.sv
src/rv_core_top.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

// File: dv/rv_core_chk.sv
`default_nettype none

module rv_core_chk (
    input logic            clk,
    input logic            rst,
    input logic            instr_valid_i,
    input logic            retire_valid_i,
    input rv_pkg::retire_t retire_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;    // Number of failed assertions.

    // Decode, execute and memory/writeback sit between issue and retire.
    a_retire_latency: assert property (@(posedge clk) disable iff (rst)
        retire_valid_i |-> $past(instr_valid_i, 3))
    else begin
        $error("Retire pulse without an instruction issued three cycles earlier.");
        fail_cnt++;
    end

    a_reset_quiet: assert property (@(posedge clk)
        ($past(rst) || $past(rst, 2)) |-> !retire_valid_i)
    else begin
        $error("Retire pulse during reset or in the cycle after it.");
        fail_cnt++;
    end

    // The idle record must be all zero.
    a_idle_zero: assert property (@(posedge clk) disable iff (rst)
        !retire_valid_i |-> (retire_i == '0))
    else begin
        $error("Retire record is not zero while no instruction retires.");
        fail_cnt++;
    end

endmodule

bind rv_core_top rv_core_chk i_rv_core_chk (
    .clk            (clk),
    .rst            (rst),
    .instr_valid_i  (instr_valid_i),
    .retire_valid_i (retire_valid_o),
    .retire_i       (retire_o)
);

`default_nettype wire

// File: dv/rv_core_tb.sv
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire_valid;
    retire_t     retire_rec;

    // Trace contents, one entry per instruction.
    string       tr_name[$];
    logic [31:0] tr_instr[$];
    int          tr_gap[$];
    retire_t     tr_exp[$];

    // Issued instructions that have not retired yet.
    string       pend_name[$];
    retire_t     pend_exp[$];

    string       cur_name;
    retire_t     cur_exp;
    int          seed = 32;
    bit          trace_loaded = 1'b0;
    int          mismatch_errs = 0;
    int          unexpected_errs = 0;
    int          missing_errs = 0;
    int          trace_errs = 0;

    rv_core_top i_rv_core_top (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .retire_valid_o (retire_valid),
        .retire_o       (retire_rec)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Trace reader and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic read_trace();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [31:0] word;
        int          gap;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        wen;
        logic        ill;
        retire_t     exp;
        fd = $fopen("dv/rv_core_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file dv/rv_core_trace.txt.");
            trace_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%s %h %d %d %h %d %d",
                               name, word, gap, rd, wdata, wen, ill);
                if (code == 7) begin
                    exp.rd      = rd;
                    exp.wdata   = wdata;
                    exp.wen     = wen;
                    exp.illegal = ill;
                    tr_name.push_back(name);
                    tr_instr.push_back(word);
                    tr_gap.push_back(gap);
                    tr_exp.push_back(exp);
                end else begin
                    $display("Malformed trace line: %s", line);
                    trace_errs++;
                end
            end
        end
        $fclose(fd);
        if (tr_name.size() == 0) begin
            $display("The trace file holds no instructions.");
            trace_errs++;
        end
    endtask

    // Called 1 ns after a rising edge; returns at the same offset.
    task automatic issue_instr(input int idx);
        int extra;
        instr_valid = 1'b1;
        instr       = tr_instr[idx];
        pend_name.push_back(tr_name[idx]);
        pend_exp.push_back(tr_exp[idx]);
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
        extra = $unsigned($random(seed)) % 3;    // Only ever widens dependency distance.
        repeat (tr_gap[idx] + extra) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic string format_retire(input retire_t r);
        return $sformatf("rd=%0d wdata=%h wen=%0b illegal=%0b", r.rd, r.wdata, r.wen, r.illegal);
    endfunction

    task automatic check_retire(input string test, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %s, actual %s",
                     test, format_retire(exp), format_retire(act));
            mismatch_errs++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (pend_exp.size() == 0) begin
                $display("Unexpected retirement with no instruction pending: %s",
                         format_retire(retire_rec));
                unexpected_errs++;
            end else begin
                cur_name = pend_name.pop_front();
                cur_exp  = pend_exp.pop_front();
                check_retire(cur_name, cur_exp, retire_rec);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        int drain;
        int assert_errs;
        int total;
        rst         = 1'b1;
        instr_valid = 1'b1;    // The DUT must drop an instruction offered while reset is high.
        instr       = 32'h0010_0093;
        read_trace();
        trace_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (tr_name[i]) begin
            issue_instr(i);
        end
        drain = 0;
        while (pend_exp.size() != 0 && drain < 8) begin
            @(posedge clk);
            drain++;
        end
        missing_errs = pend_exp.size();
        if (missing_errs != 0) begin
            $display("Missing retirements: %0d issued instructions never retired.",
                     missing_errs);
        end
        repeat (2) @(posedge clk);    // Room for a stray late pulse.
        assert_errs = i_rv_core_top.i_rv_core_chk.fail_cnt;
        total = mismatch_errs + unexpected_errs + missing_errs + trace_errs + assert_errs;
        $display("Errors: %0d mismatch, %0d unexpected, %0d missing, %0d trace, %0d assertion",
                 mismatch_errs, unexpected_errs, missing_errs, trace_errs, assert_errs);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = tr_name.size() * 6 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles.", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rv_core_trace.txt
# Columns: test name, instruction (hex), idle cycles after it, then the expected retire
# record: rd (decimal), wdata (hex), wen, illegal. A store retires its address as wdata.
lui_x1        123450B7 0  1 12345000 1 0
addi_x2       6AF00113 0  2 000006AF 1 0
addi_x3_neg   FFD00193 2  3 FFFFFFFD 1 0
add_x4        00208233 0  4 123456AF 1 0
sub_x5        401102B3 0  5 EDCBB6AF 1 0
and_x6        00317333 0  6 000006AD 1 0
or_x7         0020E3B3 0  7 123456AF 1 0
xor_x8        0030C433 0  8 EDCBAFFD 1 0
slt_x9_true   0021A4B3 0  9 00000001 1 0
slt_x10_neg   00312533 0 10 00000000 1 0
addi_x0       00510013 2  0 000006B4 0 0
read_x0       00700593 0 11 00000007 1 0
base_x12      10000613 0 12 00000100 1 0
data_x13      F8100693 2 13 FFFFFF81 1 0
sw_w0         00162023 0  0 00000100 0 0
sb_w0_lane1   00D600A3 0  1 00000101 0 0
sb_w0_lane2   00260123 0  2 00000102 0 0
sw_w1         00162223 0  4 00000104 0 0
sb_w1_lane0   00360223 0  4 00000104 0 0
sb_w1_lane3   00D603A3 0  7 00000107 0 0
sw_w2_clear   00062423 0  8 00000108 0 0
sh_w2_low     00D61423 0  8 00000108 0 0
sh_w2_high    00261523 0 10 0000010A 0 0
lw_w0         00062703 0 14 12AF8100 1 0
lw_w1         00462783 0 15 813450FD 1 0
lw_w2         00862803 0 16 06AFFF81 1 0
lb_sign       00160883 0 17 FFFFFF81 1 0
lbu_zero      00164903 0 18 00000081 1 0
lh_sign       00661983 0 19 FFFF8134 1 0
lhu_zero      00665A03 0 20 00008134 1 0
lb_lane2      00260A83 0 21 FFFFFFAF 1 0
lhu_low       00865B03 0 22 0000FF81 1 0
illegal_x14   1234570B 2 14 00000000 0 1
read_x14      00070B93 0 23 12AF8100 1 0
dep_x24       12300C13 2 24 00000123 1 0
dep_x25       001C0C93 2 25 00000124 1 0
dep_x26       018C8D33 0 26 00000247 1 0

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f build.f --top-module rv_core_tb

if ./obj_dir/Vrv_core_tb +verilator+error+limit+100 | tee /dev/stderr | grep -qx "TEST PASS"; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

// File: src/rv_core_top.sv
`default_nettype none

module rv_core_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    output logic            retire_valid_o,
    output rv_pkg::retire_t retire_o
);
    import rv_pkg::*;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            dec_valid;
    dec_ex_t         dec_ex;
    logic            ex_valid;
    ex_mem_t         ex_mem;

    rv_decode i_rv_decode (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec_ex)
    );

    rv_execute i_rv_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid_i (dec_valid),
        .dec_i       (dec_ex),
        .ex_valid_o  (ex_valid),
        .ex_o        (ex_mem)
    );

    rv_mem_wb i_rv_mem_wb (
        .clk            (clk),
        .rst            (rst),
        .ex_valid_i     (ex_valid),
        .ex_i           (ex_mem),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    // The retire record doubles as the register file write port.
    rv_regfile i_rv_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_valid_i (retire_valid_o),
        .wr_i       (retire_o)
    );

endmodule

`default_nettype wire

// File: src/rv_decode.sv
`default_nettype none

module rv_decode (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid_i,
    input  logic [31:0]    instr_i,
    output logic [4:0]     rs1_addr_o,
    output logic [4:0]     rs2_addr_o,
    input  logic [31:0]    rs1_data_i,
    input  logic [31:0]    rs2_data_i,
    output logic           dec_valid_o,
    output rv_pkg::dec_ex_t dec_o
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    dec_ex_t         dec_next;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u = {instr_i[31:12], 12'b0};

    // Register file is read in the issue cycle.
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    always_comb begin
        dec_next            = '0;
        dec_next.op_a       = rs1_data_i;
        dec_next.store_data = rs2_data_i;
        dec_next.rd         = instr_i[11:7];
        dec_next.alu_op     = ALU_ADD;
        dec_next.mem_size   = MEM_NONE;
        dec_next.illegal    = 1'b1;    // Cleared below for every known encoding.

        case (opcode)
            OPC_LUI: begin
                dec_next.op_b      = imm_u;
                dec_next.alu_op    = ALU_PASSB;
                dec_next.reg_write = 1'b1;
                dec_next.illegal   = 1'b0;
            end
            OPC_OPIMM: begin
                dec_next.op_b = imm_i;
                if (funct3 == 3'b000) begin    // ADDI only.
                    dec_next.reg_write = 1'b1;
                    dec_next.illegal   = 1'b0;
                end
            end
            OPC_OP: begin
                dec_next.op_b      = rs2_data_i;
                dec_next.reg_write = 1'b1;
                dec_next.illegal   = 1'b0;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: dec_next.alu_op = ALU_ADD;
                    {F7_ALT,  3'b000}: dec_next.alu_op = ALU_SUB;
                    {F7_BASE, 3'b111}: dec_next.alu_op = ALU_AND;
                    {F7_BASE, 3'b110}: dec_next.alu_op = ALU_OR;
                    {F7_BASE, 3'b100}: dec_next.alu_op = ALU_XOR;
                    {F7_BASE, 3'b010}: dec_next.alu_op = ALU_SLT;
                    default: begin
                        dec_next.reg_write = 1'b0;
                        dec_next.illegal   = 1'b1;
                    end
                endcase
            end
            OPC_LOAD: begin
                dec_next.op_b = imm_i;
                // funct3[2] marks LBU and LHU; there is no unsigned word load.
                if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
                    dec_next.load      = 1'b1;
                    dec_next.load_uns  = funct3[2];
                    dec_next.reg_write = 1'b1;
                    dec_next.illegal   = 1'b0;
                    dec_next.mem_size  = (funct3[1:0] == 2'b00) ? MEM_B :
                                         (funct3[1:0] == 2'b01) ? MEM_H : MEM_W;
                end
            end
            OPC_STORE: begin
                dec_next.op_b = imm_s;
                if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                    dec_next.store    = 1'b1;
                    dec_next.illegal  = 1'b0;
                    dec_next.mem_size = (funct3[1:0] == 2'b00) ? MEM_B :
                                        (funct3[1:0] == 2'b01) ? MEM_H : MEM_W;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            dec_o <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_execute.sv
`default_nettype none

module rv_execute (
    input  logic            clk,
    input  logic            rst,
    input  logic            dec_valid_i,
    input  rv_pkg::dec_ex_t dec_i,
    output logic            ex_valid_o,
    output rv_pkg::ex_mem_t ex_o
);
    import rv_pkg::*;

    logic [xlen-1:0] alu_res;
    ex_mem_t         ex_next;

    // Loads and stores go through ALU_ADD, so the same adder forms the address.
    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:   alu_res = dec_i.op_a + dec_i.op_b;
            ALU_SUB:   alu_res = dec_i.op_a - dec_i.op_b;
            ALU_AND:   alu_res = dec_i.op_a & dec_i.op_b;
            ALU_OR:    alu_res = dec_i.op_a | dec_i.op_b;
            ALU_XOR:   alu_res = dec_i.op_a ^ dec_i.op_b;
            ALU_SLT: begin
                alu_res = ($signed(dec_i.op_a) < $signed(dec_i.op_b)) ? 32'd1 : 32'd0;
            end
            ALU_PASSB: alu_res = dec_i.op_b;
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        ex_next            = '0;
        ex_next.result     = alu_res;
        ex_next.store_data = dec_i.store_data;
        ex_next.rd         = dec_i.rd;
        ex_next.mem_size   = dec_i.mem_size;
        ex_next.load       = dec_i.load;
        ex_next.load_uns   = dec_i.load_uns;
        ex_next.store      = dec_i.store;
        ex_next.reg_write  = dec_i.reg_write;
        ex_next.illegal    = dec_i.illegal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            ex_o <= ex_next;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_mem_wb.sv
`default_nettype none

module rv_mem_wb (
    input  logic            clk,
    input  logic            rst,
    input  logic            ex_valid_i,
    input  rv_pkg::ex_mem_t ex_i,
    output logic            retire_valid_o,
    output rv_pkg::retire_t retire_o
);
    import rv_pkg::*;

    logic [xlen-1:0]    dmem [dmem_words];
    logic [dmem_aw-1:0] word_idx;
    logic [1:0]         lane;
    logic [3:0]         wmask;
    logic [xlen-1:0]    wdata_rep;
    logic [xlen-1:0]    rdata_word;
    logic [7:0]         rd_byte;
    logic [15:0]        rd_half;
    logic [xlen-1:0]    load_data;
    logic [xlen-1:0]    wb_data;
    logic               wb_wen;

    assign word_idx = ex_i.result[dmem_aw+1:2];
    assign lane     = ex_i.result[1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (ex_i.mem_size)
            MEM_B:   wmask = 4'b0001 << lane;
            MEM_H:   wmask = lane[1] ? 4'b1100 : 4'b0011;
            MEM_W:   wmask = 4'b1111;
            default: wmask = 4'b0000;
        endcase
    end

    // Data is copied into every lane so the mask alone picks the target bytes.
    always_comb begin
        case (ex_i.mem_size)
            MEM_B:   wdata_rep = {4{ex_i.store_data[7:0]}};
            MEM_H:   wdata_rep = {2{ex_i.store_data[15:0]}};
            default: wdata_rep = ex_i.store_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i && ex_i.store) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    dmem[word_idx][8*i +: 8] <= wdata_rep[8*i +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load path and writeback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rdata_word = dmem[word_idx];    // Asynchronous read.
    assign rd_byte    = rdata_word[8*lane +: 8];
    assign rd_half    = lane[1] ? rdata_word[31:16] : rdata_word[15:0];

    always_comb begin
        case (ex_i.mem_size)
            MEM_B:   load_data = ex_i.load_uns ? {24'b0, rd_byte} : {{24{rd_byte[7]}}, rd_byte};
            MEM_H:   load_data = ex_i.load_uns ? {16'b0, rd_half} : {{16{rd_half[15]}}, rd_half};
            default: load_data = rdata_word;
        endcase
    end

    assign wb_data = ex_i.load ? load_data : ex_i.result;
    assign wb_wen  = ex_i.reg_write && !ex_i.illegal && (ex_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_o <= 1'b0;
            retire_o       <= '0;
        end else begin
            retire_valid_o <= ex_valid_i;
            if (ex_valid_i) begin
                retire_o.rd      <= ex_i.rd;
                retire_o.wdata   <= ex_i.illegal ? '0 : wb_data;
                retire_o.wen     <= wb_wen;
                retire_o.illegal <= ex_i.illegal;
            end else begin
                retire_o <= '0;    // Idle record is all zero.
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath and data memory geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen       = 32;
    localparam int dmem_words = 256;
    localparam int dmem_aw    = 8;    // Word address, taken from byte address bits 9:2.

    // Major opcodes of the supported subset.
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB.

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5,
        ALU_PASSB = 3'd6     // LUI result is the U immediate.
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_B    = 2'd1,
        MEM_H    = 2'd2,
        MEM_W    = 2'd3
    } mem_size_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [xlen-1:0] op_a;
        logic [xlen-1:0] op_b;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        mem_size_e       mem_size;
        logic            load;
        logic            load_uns;
        logic            store;
        logic            reg_write;
        logic            illegal;
    } dec_ex_t;

    typedef struct packed {
        logic [xlen-1:0] result;    // ALU result or effective address.
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        mem_size_e       mem_size;
        logic            load;
        logic            load_uns;
        logic            store;
        logic            reg_write;
        logic            illegal;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
        logic            wen;
        logic            illegal;
    } retire_t;

endpackage

`default_nettype wire

// File: src/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [31:0]     rs1_data_o,
    output logic [31:0]     rs2_data_o,
    input  logic            wr_valid_i,
    input  rv_pkg::retire_t wr_i
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            wr_en;

    assign wr_en = wr_valid_i && wr_i.wen && (wr_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.wdata;
        end
    end

    // Write-through lets a reader in the write cycle see the new value.
    assign rs1_data_o = (rs1_addr_i == 5'd0)                 ? '0 :
                        (wr_en && wr_i.rd == rs1_addr_i)     ? wr_i.wdata : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0)                 ? '0 :
                        (wr_en && wr_i.rd == rs2_addr_i)     ? wr_i.wdata : regs[rs2_addr_i];

endmodule

`default_nettype wire
